// ==== list.f ====
rtl/rst_pkg.sv
rtl/rst_ifs.sv
rtl/domain_reset_ctrl.sv
rtl/reset_sequencer.sv
rtl/wb_reset_regs.sv
rtl/reset_subsystem_top.sv
verif/reset_subsystem_properties.sv
verif/reset_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the reset subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module reset_subsystem_tb -f list.f \
    -Mdir obj_dir -o reset_subsystem_sim > build.log 2>&1 \
    && ./obj_dir/reset_subsystem_sim > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log \
    && { echo "simulation reported failures"; exit 1; } \
    || echo "simulation clean"

// ==== verif/reset_subsystem_tb.sv ====
`timescale 1ns/1ps
/* reset subsystem testbench
   boot, register commands, domain requests, dropped commands and stalls */
module reset_subsystem_tb import rst_pkg::*; ();

    localparam int NUM_DOMAINS  = 2;
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 2000;
    localparam logic [NUM_DOMAINS-1:0] ALL_READY = '1;
    localparam logic [NUM_DOMAINS-1:0] DOM0      = 2'b01;
    localparam logic [NUM_DOMAINS-1:0] DOM1      = 2'b10;

    logic                   sys_clk;
    logic                   async_rst_in;
    logic                   sys_clk_en;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [1:0]             wb_adr;
    logic [31:0]            wb_dat_w;
    logic [31:0]            wb_dat_r;
    logic                   wb_ack;
    logic [NUM_DOMAINS-1:0] domain_rst_req;
    logic [NUM_DOMAINS-1:0] target_rst;
    logic [NUM_DOMAINS-1:0] target_init;
    logic [NUM_DOMAINS-1:0] target_clk_en;
    int                     err_count;
    int                     check_count;

    reset_subsystem_top #(
        .NUM_DOMAINS  (NUM_DOMAINS),
        .RESET_CYCLES (RESET_CYCLES)
    ) dut_i (
        .sys_clk        (sys_clk),
        .async_rst_in   (async_rst_in),
        .sys_clk_en     (sys_clk_en),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .domain_rst_req (domain_rst_req),
        .target_rst     (target_rst),
        .target_init    (target_init),
        .target_clk_en  (target_clk_en)
    );

    always #2 sys_clk = ~sys_clk;

    task automatic abort_timeout(input string what);
        err_count++;
        $display("timeout while waiting for %s", what);
        $display("checks %0d, errors %0d", check_count, err_count);
        $display("Checks failed");
        $finish;
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("error %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    task automatic check_mask(input string name, input logic [NUM_DOMAINS-1:0] exp,
                              input logic [NUM_DOMAINS-1:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("error %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    // command register layout, opcode in 1:0 and domain in 7:4
    function automatic logic [31:0] cmd_word(input rst_op_e op, input logic [3:0] dom);
        return {24'd0, dom, 2'b00, op};
    endfunction

    task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int n;
        @(posedge sys_clk);
        #0.5;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        n = 0;
        do begin
            @(negedge sys_clk);
            n++;
            if (n > WAIT_LIMIT) begin
                abort_timeout("wishbone ack");
            end
        end while (!wb_ack);
        rdata = wb_dat_r;
        @(posedge sys_clk);
        #0.5;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic write_reg(input logic [1:0] adr, input logic [31:0] wdata);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, wdata, unused);
    endtask

    task automatic read_reg(input logic [1:0] adr, output logic [31:0] rdata);
        bus_cycle(1'b0, adr, 32'd0, rdata);
    endtask

    // polls status until busy drops
    task automatic wait_idle(output logic [31:0] status);
        int n;
        n = 0;
        read_reg(ADDR_STATUS, status);
        while (status[0]) begin
            n++;
            if (n > WAIT_LIMIT) begin
                abort_timeout("sequencer to go idle");
            end
            read_reg(ADDR_STATUS, status);
        end
    endtask

    task automatic wait_rst_high(input logic [NUM_DOMAINS-1:0] sel);
        int n;
        n = 0;
        @(negedge sys_clk);
        while ((target_rst & sel) == '0) begin
            n++;
            if (n > WAIT_LIMIT) begin
                abort_timeout("target_rst to rise");
            end
            @(negedge sys_clk);
        end
    endtask

    // enabled and total cycles of one target_rst episode
    task automatic measure_reset(input logic [NUM_DOMAINS-1:0] sel, output int enabled,
                                 output int total);
        enabled = 0;
        total = 0;
        wait_rst_high(sel);
        while ((target_rst & sel) != '0) begin
            total++;
            if (sys_clk_en) begin
                enabled++;
            end
            if (total > WAIT_LIMIT) begin
                abort_timeout("target_rst to fall");
            end
            @(negedge sys_clk);
        end
    endtask

    task automatic watch_steady(input string name, input logic [NUM_DOMAINS-1:0] sel,
                                input int cycles);
        repeat (cycles) begin
            @(negedge sys_clk);
            check_mask(name, '0, target_rst & sel);
            check_mask(name, sel, target_clk_en & sel);
        end
    endtask

    task automatic count_init(input logic [NUM_DOMAINS-1:0] sel, input int cycles,
                              output int pulses);
        pulses = 0;
        repeat (cycles) begin
            @(negedge sys_clk);
            if ((target_init & sel) != '0) begin
                pulses++;
            end
        end
    endtask

    task automatic idle_gap();
        repeat (1 + $urandom % 6) @(posedge sys_clk);
    endtask

    task automatic boot_sequence();
        int          en_cnt;
        int          all_cnt;
        int          n;
        logic [31:0] status;
        measure_reset(DOM0, en_cnt, all_cnt);
        check_word("boot dom0 reset length", 32'(RESET_CYCLES), 32'(en_cnt));
        // domain 1 stays out of reset until domain 0 is enabled
        n = 0;
        while (!target_clk_en[0]) begin
            check_bit("boot dom1 held off", 1'b0, target_rst[1]);
            n++;
            if (n > WAIT_LIMIT) begin
                abort_timeout("domain 0 clock enable after boot reset");
            end
            @(negedge sys_clk);
        end
        measure_reset(DOM1, en_cnt, all_cnt);
        check_word("boot dom1 reset length", 32'(RESET_CYCLES), 32'(en_cnt));
        wait_idle(status);
        // busy stays low once boot is over
        read_reg(ADDR_STATUS, status);
        check_mask("boot ready mask", ALL_READY, status[16 +: NUM_DOMAINS]);
        check_bit("boot busy", 1'b0, status[0]);
        check_mask("boot clock enables", ALL_READY, target_clk_en);
    endtask

    task automatic reset_command();
        int          en_cnt;
        int          all_cnt;
        logic [31:0] status;
        write_reg(ADDR_CMD, cmd_word(OP_RESET, 4'd1));
        fork
            measure_reset(DOM1, en_cnt, all_cnt);
            begin
                read_reg(ADDR_STATUS, status);
                check_mask("op_reset ready in reset", ALL_READY & ~DOM1,
                           status[16 +: NUM_DOMAINS]);
            end
            watch_steady("op_reset dom0 untouched", DOM0, RESET_CYCLES + 4);
        join
        check_word("op_reset dom1 reset length", 32'(RESET_CYCLES), 32'(en_cnt));
        wait_idle(status);
        check_mask("op_reset ready after", ALL_READY, status[16 +: NUM_DOMAINS]);
        check_mask("op_reset clock enables", ALL_READY, target_clk_en);
    endtask

    task automatic init_command();
        int          pulses0;
        int          pulses1;
        logic [31:0] status;
        fork
            write_reg(ADDR_CMD, cmd_word(OP_INIT, 4'd0));
            count_init(DOM0, 16, pulses0);
            count_init(DOM1, 16, pulses1);
            watch_steady("op_init clock enable held", ALL_READY, 16);
        join
        check_word("op_init dom0 pulses", 32'd1, 32'(pulses0));
        check_word("op_init dom1 pulses", 32'd0, 32'(pulses1));
        wait_idle(status);
        check_mask("op_init ready", ALL_READY, status[16 +: NUM_DOMAINS]);
    endtask

    task automatic domain_request();
        int          en_cnt;
        int          all_cnt;
        logic [31:0] status;
        fork
            begin
                @(posedge sys_clk);
                #0.5;
                domain_rst_req = DOM0;
                @(posedge sys_clk);
                #0.5;
                domain_rst_req = '0;
            end
            measure_reset(DOM0, en_cnt, all_cnt);
        join
        check_word("request dom0 reset length", 32'(RESET_CYCLES), 32'(en_cnt));
        wait_idle(status);
        check_mask("request ready", ALL_READY, status[16 +: NUM_DOMAINS]);
        check_mask("request clock enables", ALL_READY, target_clk_en);
    endtask

    task automatic dropped_commands();
        logic [31:0] status;
        write_reg(ADDR_CMD, cmd_word(OP_RESET, 4'd0));
        // second command lands while busy
        write_reg(ADDR_CMD, cmd_word(OP_INIT, 4'd1));
        read_reg(ADDR_STATUS, status);
        check_bit("dropped busy flag", 1'b1, status[1]);
        check_bit("dropped busy still busy", 1'b1, status[0]);
        write_reg(ADDR_STATUS, 32'h0000_0002);
        read_reg(ADDR_STATUS, status);
        check_bit("dropped busy cleared", 1'b0, status[1]);
        wait_idle(status);
        check_mask("dropped ready after reset", ALL_READY, status[16 +: NUM_DOMAINS]);
        write_reg(ADDR_CMD, cmd_word(OP_RESET, 4'd5));
        read_reg(ADDR_STATUS, status);
        check_bit("dropped domain flag", 1'b1, status[1]);
        check_bit("dropped domain not started", 1'b0, status[0]);
        write_reg(ADDR_STATUS, 32'h0000_0002);
        read_reg(ADDR_STATUS, status);
        check_bit("dropped domain cleared", 1'b0, status[1]);
    endtask

    task automatic clock_stall();
        int          en_cnt;
        int          all_cnt;
        logic [31:0] status;
        write_reg(ADDR_CMD, cmd_word(OP_RESET, 4'd1));
        fork
            measure_reset(DOM1, en_cnt, all_cnt);
            begin
                wait_rst_high(DOM1);
                repeat (5) @(negedge sys_clk);
                @(posedge sys_clk);
                #0.5;
                sys_clk_en = 1'b0;
                repeat (10) @(posedge sys_clk);
                #0.5;
                sys_clk_en = 1'b1;
            end
        join
        check_word("stall enabled reset length", 32'(RESET_CYCLES), 32'(en_cnt));
        check_word("stall total reset length", 32'(RESET_CYCLES + 10), 32'(all_cnt));
        wait_idle(status);
        check_mask("stall ready", ALL_READY, status[16 +: NUM_DOMAINS]);
    endtask

    initial begin
        sys_clk        = 1'b0;
        async_rst_in   = 1'b1;
        sys_clk_en     = 1'b1;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = 2'd0;
        wb_dat_w       = 32'd0;
        domain_rst_req = '0;
        err_count      = 0;
        check_count    = 0;
        void'($urandom(89660));
        repeat (2) @(posedge sys_clk);
        @(negedge sys_clk);
        check_mask("reset target_rst", '0, target_rst);
        check_mask("reset target_init", '0, target_init);
        check_mask("reset target_clk_en", '0, target_clk_en);
        check_bit("reset wb_ack", 1'b0, wb_ack);
        @(posedge sys_clk);
        #0.5;
        async_rst_in = 1'b0;
        boot_sequence();
        idle_gap();
        reset_command();
        idle_gap();
        init_command();
        idle_gap();
        domain_request();
        idle_gap();
        dropped_commands();
        idle_gap();
        clock_stall();
        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== verif/reset_subsystem_properties.sv ====
`timescale 1ns/1ps
/* domain controller assertions
   clock enable exclusion, response width and reset length */
module reset_subsystem_properties #(
    parameter int RESET_CYCLES = 16
) (
    input logic sys_clk,
    input logic async_rst_in,
    input logic sys_clk_en,
    input logic target_rst,
    input logic target_clk_en,
    input logic response
);

    int rst_len;

    // enabled cycles in the current reset episode
    always_ff @(posedge sys_clk or posedge async_rst_in) begin
        if (async_rst_in) begin
            rst_len <= 0;
        end else if (!target_rst) begin
            rst_len <= 0;
        end else if (sys_clk_en) begin
            rst_len <= rst_len + 1;
        end
    end

    no_clk_en_in_reset: assert property (
        @(posedge sys_clk) disable iff (async_rst_in) !(target_rst && target_clk_en)
    ) else $error("target_clk_en high while target_rst is high");

    response_one_cycle: assert property (
        @(posedge sys_clk) disable iff (async_rst_in) (response && sys_clk_en) |=> !response
    ) else $error("response wider than one enabled cycle");

    reset_length: assert property (
        @(posedge sys_clk) disable iff (async_rst_in) $fell(target_rst) |-> (rst_len == RESET_CYCLES)
    ) else $error("target_rst episode of %0d cycles", rst_len);

endmodule

bind domain_reset_ctrl reset_subsystem_properties #(
    .RESET_CYCLES (RESET_CYCLES)
) props_i (
    .sys_clk       (sys_clk),
    .async_rst_in  (async_rst_in),
    .sys_clk_en    (sys_clk_en),
    .target_rst    (target_rst),
    .target_clk_en (target_clk_en),
    .response      (resp_q)
);

// ==== rtl/reset_subsystem_top.sv ====
`timescale 1ns/1ps
/* reset and clock enable subsystem
   wishbone registers, boot sequencer and one reset controller per domain */
module reset_subsystem_top #(
    parameter int NUM_DOMAINS  = 2,
    parameter int RESET_CYCLES = 16
) (
    input  logic                   sys_clk,
    input  logic                   async_rst_in,
    input  logic                   sys_clk_en,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [1:0]             wb_adr,
    input  logic [31:0]            wb_dat_w,
    output logic [31:0]            wb_dat_r,
    output logic                   wb_ack,
    input  logic [NUM_DOMAINS-1:0] domain_rst_req,
    output logic [NUM_DOMAINS-1:0] target_rst,
    output logic [NUM_DOMAINS-1:0] target_init,
    output logic [NUM_DOMAINS-1:0] target_clk_en
);

    seq_cmd_if #(.NUM_DOMAINS(NUM_DOMAINS)) cmd_if ();
    dom_ctrl_if dom_if [NUM_DOMAINS-1:0] ();

    wb_reset_regs #(
        .NUM_DOMAINS (NUM_DOMAINS)
    ) regs_i (
        .sys_clk      (sys_clk),
        .async_rst_in (async_rst_in),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .cmd          (cmd_if)
    );

    reset_sequencer #(
        .NUM_DOMAINS (NUM_DOMAINS)
    ) seq_i (
        .sys_clk      (sys_clk),
        .async_rst_in (async_rst_in),
        .sys_clk_en   (sys_clk_en),
        .cmd          (cmd_if),
        .dom          (dom_if)
    );

    for (genvar i = 0; i < NUM_DOMAINS; i++) begin : g_domain
        domain_reset_ctrl #(
            .RESET_CYCLES (RESET_CYCLES)
        ) dom_ctrl_i (
            .sys_clk        (sys_clk),
            .async_rst_in   (async_rst_in),
            .sys_clk_en     (sys_clk_en),
            .ctrl           (dom_if[i]),
            .domain_rst_req (domain_rst_req[i]),
            .target_rst     (target_rst[i]),
            .target_init    (target_init[i]),
            .target_clk_en  (target_clk_en[i])
        );
    end

endmodule

// ==== rtl/wb_reset_regs.sv ====
`timescale 1ns/1ps
/* wishbone classic register block
   command register feeding the sequencer, and busy, dropped and ready status */
module wb_reset_regs import rst_pkg::*; #(
    parameter int NUM_DOMAINS = 2
) (
    input  logic        sys_clk,
    input  logic        async_rst_in,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    seq_cmd_if.regs     cmd
);

    logic                    access;
    logic                    wr_cmd;
    logic                    wr_status;
    rst_op_e                 wr_op;
    logic [DOMAIN_IDX_W-1:0] wr_dom;
    logic                    dom_ok;
    logic                    dropped;
    logic [7:0]              last_cmd;
    logic [31:0]             status_word;

    // no access while the previous ack is out
    assign access    = wb_cyc && wb_stb && !wb_ack;
    assign wr_cmd    = access && wb_we && (wb_adr == ADDR_CMD) && (wr_op != OP_NOP);
    assign wr_status = access && wb_we && (wb_adr == ADDR_STATUS);
    assign wr_op     = rst_op_e'(wb_dat_w[CMD_OP_LSB +: 2]);
    assign wr_dom    = wb_dat_w[CMD_DOM_LSB +: DOMAIN_IDX_W];
    assign dom_ok    = int'(wr_dom) < NUM_DOMAINS;

    assign cmd.cmd_valid  = wr_cmd && !cmd.busy && dom_ok;
    assign cmd.cmd_op     = wr_op;
    assign cmd.cmd_domain = wr_dom;

    always_comb begin
        status_word                                = '0;
        status_word[STAT_BUSY_BIT]                 = cmd.busy;
        status_word[STAT_DROP_BIT]                 = dropped;
        status_word[STAT_READY_LSB +: NUM_DOMAINS] = cmd.ready_mask;
    end

    always_ff @(posedge sys_clk or posedge async_rst_in) begin
        if (async_rst_in) begin
            wb_ack  <= 1'b0;
            dropped <= 1'b0;
        end else begin
            wb_ack <= access;
            // sticky until cleared through the status register
            if (wr_cmd && (cmd.busy || !dom_ok)) begin
                dropped <= 1'b1;
            end else if (wr_status && wb_dat_w[STAT_DROP_BIT]) begin
                dropped <= 1'b0;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (access && wb_we && (wb_adr == ADDR_CMD)) begin
            last_cmd <= wb_dat_w[7:0];
        end
        if (access && !wb_we) begin
            case (wb_adr)
                ADDR_CMD:    wb_dat_r <= {24'd0, last_cmd};
                ADDR_STATUS: wb_dat_r <= status_word;
                default:     wb_dat_r <= '0;
            endcase
        end
    end

endmodule

// ==== rtl/reset_sequencer.sv ====
`timescale 1ns/1ps
/* reset sequencer
   boots every domain through reset, init and enable, then serves
   register commands and reset requests raised by the domains */
module reset_sequencer import rst_pkg::*; #(
    parameter int NUM_DOMAINS = 2
) (
    input  logic    sys_clk,
    input  logic    async_rst_in,
    input  logic    sys_clk_en,
    seq_cmd_if.seq  cmd,
    dom_ctrl_if.seq dom [NUM_DOMAINS-1:0]
);

    localparam logic [DOMAIN_IDX_W-1:0] LAST_DOM = DOMAIN_IDX_W'(NUM_DOMAINS - 1);

    seq_state_e              state;
    seq_state_e              state_d;
    rst_op_e                 cur_op;
    rst_op_e                 cur_op_d;
    logic [DOMAIN_IDX_W-1:0] cur_dom;
    logic [DOMAIN_IDX_W-1:0] cur_dom_d;
    logic [NUM_DOMAINS-1:0]  cur_onehot;
    logic                    booting;
    logic [DOMAIN_IDX_W-1:0] boot_idx;
    logic                    boot_step;
    logic [NUM_DOMAINS-1:0]  ready_mask;
    logic [NUM_DOMAINS-1:0]  req_pending;
    logic [NUM_DOMAINS-1:0]  req_vec;
    logic [NUM_DOMAINS-1:0]  resp_vec;
    logic                    req_found;
    logic [DOMAIN_IDX_W-1:0] req_idx;
    logic                    dom_resp;
    logic                    seq_done;

    function automatic seq_state_e first_state(input rst_op_e op);
        case (op)
            OP_RESET:  return S_RESET;
            OP_INIT:   return S_INIT;
            OP_ENABLE: return S_ENABLE;
            default:   return S_IDLE;
        endcase
    endfunction

    assign cur_onehot = NUM_DOMAINS'(1) << cur_dom;

    for (genvar i = 0; i < NUM_DOMAINS; i++) begin : g_dom
        assign dom[i].rst_cmd    = (state == S_RESET) && cur_onehot[i];
        assign dom[i].init_cmd   = (state == S_INIT) && cur_onehot[i];
        assign dom[i].clk_en_cmd = (state == S_ENABLE) && cur_onehot[i];
        assign resp_vec[i]       = dom[i].response;
        assign req_vec[i]        = dom[i].rst_request;
    end

    assign dom_resp = |(resp_vec & cur_onehot);
    assign seq_done = dom_resp && ((state == S_ENABLE_WAIT) ||
                                   (state == S_INIT_WAIT && cur_op == OP_INIT));

    // lowest pending request wins
    always_comb begin
        req_found = 1'b0;
        req_idx   = '0;
        for (int i = NUM_DOMAINS - 1; i >= 0; i--) begin
            if (req_pending[i]) begin
                req_found = 1'b1;
                req_idx   = DOMAIN_IDX_W'(i);
            end
        end
    end

    always_comb begin
        state_d   = state;
        cur_op_d  = cur_op;
        cur_dom_d = cur_dom;
        boot_step = 1'b0;
        case (state)
            S_IDLE: begin
                if (cmd.cmd_valid) begin
                    cur_op_d  = cmd.cmd_op;
                    cur_dom_d = cmd.cmd_domain;
                    state_d   = first_state(cmd.cmd_op);
                end else if (booting) begin
                    cur_op_d  = OP_RESET;
                    cur_dom_d = boot_idx;
                    state_d   = S_RESET;
                    boot_step = 1'b1;
                end else if (req_found) begin
                    cur_op_d  = OP_RESET;
                    cur_dom_d = req_idx;
                    state_d   = S_RESET;
                end
            end
            S_RESET:       state_d = S_RESET_WAIT;
            S_RESET_WAIT:  state_d = dom_resp ? S_INIT : S_RESET_WAIT;
            S_INIT:        state_d = S_INIT_WAIT;
            S_INIT_WAIT: begin
                if (dom_resp) begin
                    state_d = (cur_op == OP_INIT) ? S_IDLE : S_ENABLE;
                end
            end
            S_ENABLE:      state_d = S_ENABLE_WAIT;
            S_ENABLE_WAIT: state_d = dom_resp ? S_IDLE : S_ENABLE_WAIT;
            default:       state_d = S_IDLE;
        endcase
        // boot runs domains back to back
        if (seq_done && booting) begin
            cur_op_d  = OP_RESET;
            cur_dom_d = boot_idx;
            state_d   = S_RESET;
            boot_step = 1'b1;
        end
    end

    always_ff @(posedge sys_clk or posedge async_rst_in) begin
        if (async_rst_in) begin
            state       <= S_IDLE;
            cur_op      <= OP_NOP;
            cur_dom     <= '0;
            booting     <= 1'b1;
            boot_idx    <= '0;
            ready_mask  <= '0;
            req_pending <= '0;
        end else if (sys_clk_en) begin
            state   <= state_d;
            cur_op  <= cur_op_d;
            cur_dom <= cur_dom_d;
            if (boot_step) begin
                boot_idx <= boot_idx + DOMAIN_IDX_W'(1);
                if (boot_idx == LAST_DOM) begin
                    booting <= 1'b0;
                end
            end
            if (state == S_RESET) begin
                ready_mask <= ready_mask & ~cur_onehot;
            end else if (state == S_ENABLE_WAIT && dom_resp) begin
                ready_mask <= ready_mask | cur_onehot;
            end
            // a started reset serves that domain's request
            req_pending <= (req_pending & ~((state == S_RESET) ? cur_onehot : '0)) | req_vec;
        end
    end

    assign cmd.busy       = (state != S_IDLE);
    assign cmd.ready_mask = ready_mask;

endmodule

// ==== rtl/domain_reset_ctrl.sv ====
`timescale 1ns/1ps
/* per-domain reset controller
   stretches a reset command to RESET_CYCLES cycles, buffers init and
   clock enable, and answers every command with a one-cycle response */
module domain_reset_ctrl #(
    parameter int RESET_CYCLES = 16
) (
    input  logic    sys_clk,
    input  logic    async_rst_in,
    input  logic    sys_clk_en,
    dom_ctrl_if.dom ctrl,
    input  logic    domain_rst_req,
    output logic    target_rst,
    output logic    target_init,
    output logic    target_clk_en
);

    localparam int               CNT_W    = (RESET_CYCLES > 1) ? $clog2(RESET_CYCLES) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(RESET_CYCLES - 1);

    logic             rst_delay;
    logic             rst_active;
    logic [CNT_W-1:0] rst_cnt;
    logic             rst_end;
    logic             init_q;
    logic             clk_en_q;
    logic             resp_q;

    // last cycle of the stretched reset
    assign rst_end = rst_active && (rst_cnt == CNT_LAST);

    // command delay stage
    always_ff @(posedge sys_clk or posedge async_rst_in) begin
        if (async_rst_in) begin
            rst_delay <= 1'b0;
        end else if (sys_clk_en) begin
            rst_delay <= ctrl.rst_cmd;
        end
    end

    // pulse extender
    always_ff @(posedge sys_clk or posedge async_rst_in) begin
        if (async_rst_in) begin
            rst_active <= 1'b0;
        end else if (sys_clk_en) begin
            if (rst_delay) begin
                rst_active <= 1'b1;
            end else if (rst_end) begin
                rst_active <= 1'b0;
            end
        end
    end

    always_ff @(posedge sys_clk or posedge async_rst_in) begin
        if (async_rst_in) begin
            rst_cnt <= '0;
        end else if (sys_clk_en) begin
            if (rst_delay) begin
                rst_cnt <= '0;
            end else if (rst_active && !rst_end) begin
                rst_cnt <= rst_cnt + CNT_W'(1);
            end
        end
    end

    // init buffer, one cycle per command
    always_ff @(posedge sys_clk or posedge async_rst_in) begin
        if (async_rst_in) begin
            init_q <= 1'b0;
        end else if (sys_clk_en) begin
            init_q <= ctrl.init_cmd;
        end
    end

    // clock enable held until the next reset
    always_ff @(posedge sys_clk or posedge async_rst_in) begin
        if (async_rst_in) begin
            clk_en_q <= 1'b0;
        end else if (sys_clk_en) begin
            if (rst_delay || rst_active) begin
                clk_en_q <= 1'b0;
            end else if (ctrl.clk_en_cmd) begin
                clk_en_q <= 1'b1;
            end
        end
    end

    // reset end, init and enable all complete here
    always_ff @(posedge sys_clk or posedge async_rst_in) begin
        if (async_rst_in) begin
            resp_q <= 1'b0;
        end else if (sys_clk_en) begin
            resp_q <= rst_end || init_q || ctrl.clk_en_cmd;
        end
    end

    assign target_rst       = rst_active;
    assign target_init      = init_q;
    assign target_clk_en    = clk_en_q;
    assign ctrl.response    = resp_q;
    assign ctrl.rst_request = domain_rst_req;

endmodule

// ==== rtl/rst_ifs.sv ====
`timescale 1ns/1ps
/* control interfaces of the reset subsystem
   domain commands and responses, and the register to sequencer path */

// one instance per target domain
interface dom_ctrl_if;
    logic clk_en_cmd;
    logic rst_cmd;
    logic init_cmd;
    logic rst_request;
    logic response;

    modport seq (
        output clk_en_cmd,
        output rst_cmd,
        output init_cmd,
        input  rst_request,
        input  response
    );

    modport dom (
        input  clk_en_cmd,
        input  rst_cmd,
        input  init_cmd,
        output rst_request,
        output response
    );
endinterface

interface seq_cmd_if import rst_pkg::*; #(
    parameter int NUM_DOMAINS = 2
);
    logic                    cmd_valid;
    rst_op_e                 cmd_op;
    logic [DOMAIN_IDX_W-1:0] cmd_domain;
    logic                    busy;
    logic [NUM_DOMAINS-1:0]  ready_mask;

    modport regs (
        output cmd_valid,
        output cmd_op,
        output cmd_domain,
        input  busy,
        input  ready_mask
    );

    modport seq (
        input  cmd_valid,
        input  cmd_op,
        input  cmd_domain,
        output busy,
        output ready_mask
    );
endinterface

// ==== rtl/rst_pkg.sv ====
/* reset subsystem package
   command opcodes, sequencer states and register map constants */
package rst_pkg;

    // width of the domain index field
    localparam int DOMAIN_IDX_W = 4;

    // wishbone word addresses
    localparam logic [1:0] ADDR_CMD    = 2'd0;
    localparam logic [1:0] ADDR_STATUS = 2'd1;

    // command register fields
    localparam int CMD_OP_LSB  = 0;
    localparam int CMD_DOM_LSB = 4;

    // status register fields
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_DROP_BIT  = 1;
    localparam int STAT_READY_LSB = 16;

    typedef enum logic [1:0] {
        OP_NOP    = 2'd0,
        OP_RESET  = 2'd1,
        OP_INIT   = 2'd2,
        OP_ENABLE = 2'd3
    } rst_op_e;

    typedef enum logic [2:0] {
        S_IDLE        = 3'd0,
        S_RESET       = 3'd1,
        S_RESET_WAIT  = 3'd2,
        S_INIT        = 3'd3,
        S_INIT_WAIT   = 3'd4,
        S_ENABLE      = 3'd5,
        S_ENABLE_WAIT = 3'd6
    } seq_state_e;

endpackage
